// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_sdmac
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
sdmac_pkg.sv
sdmac_addr_decoder.sv
sdmac_ctrl_regs.sv
sdmac_xfer_engine.sv
sdmac_status_merge.sv
sdmac_top.sv
tb_sdmac.sv

// File: sdmac_addr_decoder.sv
// Decodes the APB access phase into register selects, direction qualifiers and action strobes
`timescale 1ns/1ps

module sdmac_addr_decoder (
  input  sdmac_pkg::apb_req_t req,
  output sdmac_pkg::reg_sel_t sel
);

  logic access;

  // Same role as the chip select plus address strobe on the old bus
  assign access = req.sel & req.enable;

  always_comb begin
    sel = '0;
    if (access) begin
      case (req.addr)
        // Read/write registers
        sdmac_pkg::WTC:     sel.wtc     = 1'b1;
        sdmac_pkg::CONTR:   sel.contr   = 1'b1;
        sdmac_pkg::ACR:     sel.acr     = 1'b1;
        sdmac_pkg::SSPBDAT: sel.sspbdat = 1'b1;

        // Read only
        sdmac_pkg::ISTR: begin
          if (req.write) sel.miss = 1'b1;
          else           sel.istr = 1'b1;
        end
        sdmac_pkg::VERSION: begin
          if (req.write) sel.miss    = 1'b1;
          else           sel.version = 1'b1;
        end

        // Write strobes, data ignored
        sdmac_pkg::ST_DMA: begin
          if (req.write) sel.st_dma = 1'b1;
          else           sel.miss   = 1'b1;
        end
        sdmac_pkg::SP_DMA: begin
          if (req.write) sel.sp_dma = 1'b1;
          else           sel.miss   = 1'b1;
        end
        sdmac_pkg::CLR_INT: begin
          if (req.write) sel.clr_int = 1'b1;
          else           sel.miss    = 1'b1;
        end
        sdmac_pkg::FLUSH: begin
          if (req.write) sel.flush = 1'b1;
          else           sel.miss  = 1'b1;
        end

        default: sel.miss = 1'b1;  // Hole in the map
      endcase

      sel.wr = req.write & ~sel.miss;
      sel.rd = ~req.write & ~sel.miss;
    end
  end

  // An access never targets more than one register or strobe, and never hits and misses
  always_comb begin
    assert ($onehot0({sel.wtc, sel.contr, sel.acr, sel.istr, sel.version, sel.sspbdat,
                      sel.st_dma, sel.sp_dma, sel.clr_int, sel.flush, sel.miss}))
      else $error("decoder selected more than one target at 0x%02h", req.addr);
  end

endmodule

// File: sdmac_ctrl_regs.sv
// Control register block with CONTR and SSPBDAT, feeding the engine and the read mux
`timescale 1ns/1ps

module sdmac_ctrl_regs (
  input  logic                cpuclk,
  input  logic                arst_n,
  input  sdmac_pkg::apb_req_t req,
  input  sdmac_pkg::reg_sel_t sel,
  output sdmac_pkg::contr_t   contr,
  output logic [31:0]         sspbdat
);

  logic contr_we;
  logic sspbdat_we;

  assign contr_we   = sel.wr & sel.contr;
  assign sspbdat_we = sel.wr & sel.sspbdat;

  // CONTR, reserved bits dropped on the way in
  always_ff @(posedge cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      contr <= '0;
    end else if (contr_we) begin
      contr <= sdmac_pkg::contr_t'(req.wdata & sdmac_pkg::CONTR_WMASK);
    end
  end

  // Scratch word, no side effects
  always_ff @(posedge cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      sspbdat <= '0;
    end else if (sspbdat_we) begin
      sspbdat <= req.wdata;  // Full 32 bits
    end
  end

  // Reserved CONTR bits stay clear whatever the host writes
  a_contr_rsvd_zero : assert property (
    @(posedge cpuclk) disable iff (!arst_n)
      (contr.rsvd_hi == '0) && !contr.rsvd_lo
  ) else $error("reserved CONTR bits set: 0x%08h", contr);

endmodule

// File: sdmac_pkg.sv
// Shared register map, engine states, bus structs and constants for the SCSI DMA controller
package sdmac_pkg;

  // Register offsets on the 8-bit APB address
  typedef enum logic [7:0] {
    WTC     = 8'h04,  // Word transfer count
    CONTR   = 8'h08,  // Control register
    ACR     = 8'h0C,  // Address counter
    ST_DMA  = 8'h10,  // Start strobe
    FLUSH   = 8'h14,  // Flush strobe
    CLR_INT = 8'h18,  // Interrupt clear strobe
    ISTR    = 8'h1C,  // Interrupt status, read only
    VERSION = 8'h20,  // Version, read only
    SP_DMA  = 8'h3C,  // Stop strobe
    SSPBDAT = 8'h58   // Scratch data word
  } reg_addr_e;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    DONE = 2'd2
  } xfer_state_e;

  localparam int          WTC_W         = 24;
  localparam logic [31:0] VERSION_VALUE = 32'h0000_0301;
  localparam logic [31:0] ACR_STEP      = 32'd4;         // One 32-bit word per acknowledge
  localparam logic [31:0] CONTR_WMASK   = 32'h0000_0006; // Only dmadir and inten are writable

  // APB request fields as seen by the blocks
  typedef struct packed {
    logic        sel;
    logic        enable;
    logic        write;
    logic [7:0]  addr;
    logic [31:0] wdata;
  } apb_req_t;

  // Decoded access, all zero outside the access phase
  typedef struct packed {
    logic wr;       // Legal write
    logic rd;       // Legal read
    logic wtc;
    logic contr;
    logic acr;
    logic istr;
    logic version;
    logic sspbdat;
    logic st_dma;
    logic sp_dma;
    logic clr_int;
    logic flush;
    logic miss;     // Unmapped offset or wrong direction
  } reg_sel_t;

  typedef struct packed {
    logic [28:0] rsvd_hi;
    logic        inten;   // Interrupt enable
    logic        dmadir;  // 1 = peripheral to memory
    logic        rsvd_lo;
  } contr_t;

  typedef struct packed {
    logic [25:0] rsvd_hi;
    xfer_state_e state;
    logic [2:0]  rsvd_mid;
    logic        int_p;    // Transfer finished, pending
  } istr_t;

  typedef struct packed {
    xfer_state_e        state;
    logic [31:0]        acr;
    logic [WTC_W-1:0]   wtc;
    logic               tc_pulse;  // Run ended by count or flush
  } engine_stat_t;

endpackage

// File: sdmac_status_merge.sv
// Merges engine and register results into ISTR, read data, slave error and the interrupt line
`timescale 1ns/1ps

module sdmac_status_merge (
  input  logic                    cpuclk,
  input  logic                    arst_n,
  input  sdmac_pkg::reg_sel_t     sel,
  input  sdmac_pkg::contr_t       contr,
  input  logic [31:0]             sspbdat,
  input  sdmac_pkg::engine_stat_t stat,
  output logic [31:0]             prdata,
  output logic                    pready,
  output logic                    pslverr,
  output logic                    int_n
);

  logic              int_p;
  sdmac_pkg::istr_t  istr;

  // INT_P, set has priority over a clear on the same edge
  always_ff @(posedge cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      int_p <= 1'b0;
    end else if (stat.tc_pulse) begin
      int_p <= 1'b1;
    end else if (sel.clr_int) begin
      int_p <= 1'b0;
    end
  end

  always_comb begin
    istr       = '0;
    istr.state = stat.state;  // Bits 5:4
    istr.int_p = int_p;
  end

  // Read mux, zero when no legal read is in progress
  always_comb begin
    prdata = '0;
    if (sel.rd) begin
      if (sel.wtc)     prdata = 32'(stat.wtc);
      if (sel.contr)   prdata = contr;
      if (sel.acr)     prdata = stat.acr;
      if (sel.istr)    prdata = istr;
      if (sel.version) prdata = sdmac_pkg::VERSION_VALUE;
      if (sel.sspbdat) prdata = sspbdat;
    end
  end

  assign pready  = sel.rd | sel.wr | sel.miss;  // Every access phase, no wait states
  assign pslverr = sel.miss;
  assign int_n   = ~(int_p & contr.inten);

endmodule

// File: sdmac_top.sv
// Top level of the SCSI DMA register and transfer control, APB slave plus peripheral request pins
`timescale 1ns/1ps

module sdmac_top (
  input  logic        cpuclk,
  input  logic        arst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  input  logic        dreq,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        dack,
  output logic [31:0] dma_addr,
  output logic        dma_dir,
  output logic        int_n
);

  sdmac_pkg::apb_req_t     req;
  sdmac_pkg::reg_sel_t     sel;
  sdmac_pkg::contr_t       contr;
  sdmac_pkg::engine_stat_t stat;
  logic [31:0]             sspbdat;

  assign req = '{sel: psel, enable: penable, write: pwrite, addr: paddr, wdata: pwdata};

  sdmac_addr_decoder u_decoder (
    .req (req),
    .sel (sel)
  );

  sdmac_ctrl_regs u_ctrl_regs (
    .cpuclk  (cpuclk),
    .arst_n  (arst_n),
    .req     (req),
    .sel     (sel),
    .contr   (contr),
    .sspbdat (sspbdat)
  );

  sdmac_xfer_engine u_engine (
    .cpuclk   (cpuclk),
    .arst_n   (arst_n),
    .req      (req),
    .sel      (sel),
    .contr    (contr),
    .dreq     (dreq),
    .dack     (dack),
    .dma_addr (dma_addr),
    .dma_dir  (dma_dir),
    .stat     (stat)
  );

  sdmac_status_merge u_merge (
    .cpuclk  (cpuclk),
    .arst_n  (arst_n),
    .sel     (sel),
    .contr   (contr),
    .sspbdat (sspbdat),
    .stat    (stat),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .int_n   (int_n)
  );

endmodule

// File: sdmac_trace.txt
# W addr data exp_err | R addr exp_data exp_err | Q cycles exp_acks | I exp_int_n | A exp_addr
# All fields in hex, one operation per line
R 04 00000000 0
R 08 00000000 0
R 0C 00000000 0
R 1C 00000000 0
R 20 00000301 0
R 58 00000000 0
I 1
W 08 ffffffff 0
R 08 00000006 0
W 08 00000004 0
W 58 5a3c96e1 0
R 58 5a3c96e1 0
W 0C 00001000 0
W 04 00000005 0
W 10 00000000 0
Q 8 5
R 1C 00000021 0
R 04 00000000 0
A 00001014
I 0
W 18 00000000 0
I 1
W 10 00000000 0
R 1C 00000021 0
I 0
W 08 00000002 0
I 1
W 18 00000000 0
W 0C 00002000 0
W 04 00000008 0
W 10 00000000 0
Q 3 3
R 1C 00000010 0
W 0C 0000ffff 0
R 0C 0000200c 0
W 3C 00000000 0
Q 4 0
R 1C 00000000 0
R 04 00000005 0
W 10 00000000 0
Q 2 2
W 14 00000000 0
R 1C 00000021 0
R 04 00000003 0
A 00002014
W 18 00000000 0
R 30 00000000 1
R 10 00000000 1
R 18 00000000 1
R 3C 00000000 1
W 1C ffffffff 1
W 20 ffffffff 1
W 40 ffffffff 1
R 1C 00000020 0
R 08 00000002 0
R 58 5a3c96e1 0
R 0C 00002014 0

// File: sdmac_xfer_engine.sv
// Transfer engine holding ACR and WTC, running start/stop/flush and acknowledging peripheral requests
`timescale 1ns/1ps

module sdmac_xfer_engine (
  input  logic                    cpuclk,
  input  logic                    arst_n,
  input  sdmac_pkg::apb_req_t     req,
  input  sdmac_pkg::reg_sel_t     sel,
  input  sdmac_pkg::contr_t       contr,
  input  logic                    dreq,
  output logic                    dack,
  output logic [31:0]             dma_addr,
  output logic                    dma_dir,
  output sdmac_pkg::engine_stat_t stat
);

  sdmac_pkg::xfer_state_e           state;
  sdmac_pkg::xfer_state_e           state_nxt;
  logic [31:0]                      acr;
  logic [sdmac_pkg::WTC_W-1:0]      wtc;
  logic                             run_end;   // Count or flush finishes the run
  logic                             tc_pulse;
  logic                             running;

  assign running  = (state == sdmac_pkg::RUN);
  assign dack     = dreq & running;  // One word per high cycle, no back-pressure
  assign dma_addr = acr;
  assign dma_dir  = contr.dmadir;

  always_comb begin
    state_nxt = state;
    run_end   = 1'b0;
    case (state)
      sdmac_pkg::IDLE, sdmac_pkg::DONE: begin
        if (sel.st_dma) begin
          if (wtc != '0) begin
            state_nxt = sdmac_pkg::RUN;
          end else begin
            state_nxt = sdmac_pkg::DONE;  // Nothing to move
            run_end   = 1'b1;
          end
        end
      end
      sdmac_pkg::RUN: begin
        if (sel.flush || (dack && wtc == 1)) begin
          state_nxt = sdmac_pkg::DONE;
          run_end   = 1'b1;
        end
      end
      default: state_nxt = sdmac_pkg::IDLE;
    endcase
    // Stop overrides everything and raises no interrupt
    if (sel.sp_dma) begin
      state_nxt = sdmac_pkg::IDLE;
      run_end   = 1'b0;
    end
  end

  always_ff @(posedge cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= sdmac_pkg::IDLE;
      tc_pulse <= 1'b0;
    end else begin
      state    <= state_nxt;
      tc_pulse <= run_end;  // High in the first cycle of DONE
    end
  end

  // Counters step per acknowledged word and load from the host only when not running
  always_ff @(posedge cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      acr <= '0;
      wtc <= '0;
    end else if (dack) begin
      acr <= acr + sdmac_pkg::ACR_STEP;
      wtc <= wtc - 1'b1;
    end else if (!running) begin
      if (sel.wr && sel.acr) acr <= req.wdata;
      if (sel.wr && sel.wtc) wtc <= req.wdata[sdmac_pkg::WTC_W-1:0];
    end
  end

  assign stat = '{state: state, acr: acr, wtc: wtc, tc_pulse: tc_pulse};

  // Acknowledge only inside a run that still has words left
  a_dack_in_run : assert property (
    @(posedge cpuclk) disable iff (!arst_n)
      dack |-> running && (wtc != '0)
  ) else $error("dack outside RUN or with WTC at zero");

  // Every acknowledge takes WTC strictly down, so it never wraps
  a_wtc_no_wrap : assert property (
    @(posedge cpuclk) disable iff (!arst_n)
      dack |=> (wtc < $past(wtc))
  ) else $error("WTC wrapped below zero");

endmodule

// File: tb_sdmac.sv
// Testbench for sdmac_top, replays sdmac_trace.txt over APB and the dreq pin and checks the results
`timescale 1ns/1ps

module tb_sdmac;

  logic        cpuclk;
  logic        arst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic        dreq;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        dack;
  logic [31:0] dma_addr;
  logic        dma_dir;
  logic        int_n;

  int checks;
  int data_errors;
  int err_errors;
  int int_errors;
  int dir_errors;
  int trace_errors;
  int timeouts;

  sdmac_top uut (
    .cpuclk   (cpuclk),
    .arst_n   (arst_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .dreq     (dreq),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .dack     (dack),
    .dma_addr (dma_addr),
    .dma_dir  (dma_dir),
    .int_n    (int_n)
  );

  initial begin
    cpuclk = 1'b0;
    forever #5 cpuclk = ~cpuclk;  // 10 ns period
  end

  task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      data_errors++;
      $display("error %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_err(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      err_errors++;
      $display("error pslverr got 0x%0h expected 0x%0h at %0t", got, exp, $time);
    end
  endtask

  task automatic check_int(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      int_errors++;
      $display("error int_n got 0x%0h expected 0x%0h at %0t", got, exp, $time);
    end
  endtask

  task automatic check_dir(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      dir_errors++;
      $display("error dma_dir got 0x%0h expected 0x%0h at %0t", got, exp, $time);
    end
  endtask

  // Setup then access phase, outputs sampled mid-cycle once pready is up
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int waited;
    waited  = 0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge cpuclk);
    #1;
    penable = 1'b1;
    @(negedge cpuclk);
    while (!pready && waited < 20) begin
      @(negedge cpuclk);
      waited++;
    end
    rdata = prdata;
    err   = pslverr;
    if (!pready) begin
      timeouts++;
      $display("APB access to 0x%02h saw no pready within 20 cycles", addr);
    end
    @(posedge cpuclk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic request_words(input int cycles, output int acks);
    acks = 0;
    dreq = 1'b1;
    repeat (cycles) begin
      @(negedge cpuclk);
      if (dack) acks++;
      @(posedge cpuclk);
      #1;
    end
    dreq = 1'b0;
  endtask

  task automatic idle_cycles();
    int k;
    k = $urandom_range(3, 0);
    repeat (k) begin
      @(posedge cpuclk);
      #1;
    end
  endtask

  task automatic field_count(input int got, input int want, input logic [7:0] op);
    if (got != want) begin
      trace_errors++;
      $display("trace line for '%c' has %0d fields instead of %0d", op, got, want);
    end
  endtask

  task automatic finish_run();
    int total;
    total = data_errors + err_errors + int_errors + dir_errors + trace_errors + timeouts;
    $display(
      "checks %0d, errors data %0d pslverr %0d int_n %0d dma_dir %0d trace %0d timeouts %0d",
      checks, data_errors, err_errors, int_errors, dir_errors, trace_errors, timeouts);
    if (total == 0 && checks > 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  endtask

  initial begin
    int          fd;
    int          n;
    int          cycles;
    int          exp_acks;
    int          acks;
    logic [7:0]  op;
    string       line;
    logic [7:0]  addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [31:0] exp_data;
    logic        err;
    logic        exp_err;
    logic        exp_dir;
    void'($urandom(32'h67a5));
    exp_dir = 1'b0;  // CONTR resets to zero
    arst_n  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    dreq    = 1'b0;
    repeat (16) @(posedge cpuclk);
    #1 arst_n = 1'b1;
    @(posedge cpuclk);
    #1;
    fd = $fopen("sdmac_trace.txt", "r");
    if (fd == 0) begin
      trace_errors++;
      $display("could not open sdmac_trace.txt");
    end else begin
      while (timeouts == 0 && $fscanf(fd, " %c", op) == 1) begin
        case (op)
          "#": n = $fgets(line, fd);  // Comment line
          "W": begin
            n = $fscanf(fd, "%h %h %h", addr, wdata, exp_err);
            field_count(n, 3, op);
            apb_access(1'b1, addr, wdata, rdata, err);
            check_err(err, exp_err);
            if (addr == sdmac_pkg::CONTR && !exp_err) exp_dir = wdata[1];  // dmadir bit
          end
          "R": begin
            n = $fscanf(fd, "%h %h %h", addr, exp_data, exp_err);
            field_count(n, 3, op);
            apb_access(1'b0, addr, '0, rdata, err);
            check_data("prdata", rdata, exp_data);
            check_err(err, exp_err);
          end
          "Q": begin
            n = $fscanf(fd, "%h %h", cycles, exp_acks);
            field_count(n, 2, op);
            request_words(cycles, acks);
            check_data("dack count", 32'(acks), 32'(exp_acks));
          end
          "I", "A": begin
            n = $fscanf(fd, "%h", exp_data);
            field_count(n, 1, op);
            @(negedge cpuclk);
            if (op == "I") check_int(int_n, exp_data[0]);
            else           check_data("dma_addr", dma_addr, exp_data);
            check_dir(dma_dir, exp_dir);
            @(posedge cpuclk);
            #1;
          end
          default: begin
            trace_errors++;
            $display("unknown trace operation '%c'", op);
            n = $fgets(line, fd);
          end
        endcase
        if (op != "#") idle_cycles();
      end
      $fclose(fd);
    end
    finish_run();
  end

  // Watchdog against a stuck trace or clock
  initial begin
    repeat (50000) @(posedge cpuclk);
    timeouts++;
    $display("simulation did not end within 50000 cycles");
    finish_run();
  end

endmodule
